//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module fpu_tb

sim:
	verilator --binary --timing --assert -f sim.f --top-module fpu_tb -o fpu_tb_sim
	./obj_dir/fpu_tb_sim | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/fpu_execute.sv
// calculation stage: add and subtract, sign injection, min and max, compares
`default_nettype none
`include "fpu_settings.svh"

module fpu_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  logic                   al_valid,
    input  fpu_pkg::fpu_op_e       al_op,
    input  logic [`FPU_TAG_W-1:0]  al_tag,
    input  logic                   al_as,
    input  logic                   al_bs,
    input  logic [`FPU_EXP_W-1:0]  al_ae,
    input  logic [`FPU_EXP_W-1:0]  al_be,
    input  logic [`FPU_MANT_W-1:0] al_am,
    input  logic [`FPU_MANT_W-1:0] al_bm,
    input  logic [`FPU_MANT_W-1:0] al_a2,
    input  logic [`FPU_MANT_W-1:0] al_b2,
    input  logic [`FPU_EXP_W-1:0]  al_me,
    output logic                   ex_valid,
    output logic [`FPU_TAG_W-1:0]  ex_tag,
    output fpu_pkg::fpu_kind_e     ex_kind,
    output logic                   ex_s,
    output logic [`FPU_EXP_W-1:0]  ex_e,
    output logic [`FPU_MANT_W-1:0] ex_m
);
    logic [`FPU_MANT_W-1:0] sum;
    logic                   sum_s;
    logic [`FPU_MANT_W-1:0] sum_m;
    logic                   a_lt_b;
    logic                   a_eq_b;

    always_comb begin
        sum    = (al_op == fpu_pkg::op_fsub) ? al_a2 - al_b2 : al_a2 + al_b2;
        sum_s  = sum[`FPU_MANT_W-1];
        sum_m  = sum_s ? -sum : sum; // back to sign and magnitude
        a_lt_b = $signed(al_a2) < $signed(al_b2);
        a_eq_b = al_a2 == al_b2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (advance) begin
            ex_valid <= al_valid;
        end
        if (advance) begin
            ex_tag  <= al_tag;
            ex_kind <= fpu_pkg::kind_pass;
            ex_s    <= al_as;
            ex_e    <= al_ae;
            ex_m    <= al_am;
            case (al_op)
                fpu_pkg::op_fadd, fpu_pkg::op_fsub: begin
                    ex_kind <= fpu_pkg::kind_float;
                    ex_s    <= sum_s;
                    ex_e    <= al_me - `FPU_EXP_W'(1); // aligned sum sits one bit higher
                    ex_m    <= sum_m;
                end
                fpu_pkg::op_fsgnj:  ex_s <= al_bs;
                fpu_pkg::op_fsgnjn: ex_s <= ~al_bs;
                fpu_pkg::op_fsgnjx: ex_s <= al_as ^ al_bs;
                fpu_pkg::op_fmin: begin
                    if (!a_lt_b) begin // ties return b
                        ex_s <= al_bs;
                        ex_e <= al_be;
                        ex_m <= al_bm;
                    end
                end
                fpu_pkg::op_fmax: begin
                    if (a_lt_b || a_eq_b) begin
                        ex_s <= al_bs;
                        ex_e <= al_be;
                        ex_m <= al_bm;
                    end
                end
                default: begin // compares
                    ex_kind <= fpu_pkg::kind_int;
                    ex_s    <= 1'b0;
                    ex_e    <= '0;
                    ex_m    <= '0;
                    if (al_op == fpu_pkg::op_feq) begin
                        ex_m[0] <= a_eq_b;
                    end else if (al_op == fpu_pkg::op_flt) begin
                        ex_m[0] <= a_lt_b;
                    end else if (al_op == fpu_pkg::op_fle) begin
                        ex_m[0] <= a_lt_b | a_eq_b;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/fpu_issue_queue.sv
// issue queue holding accepted FPU requests in order until the pipeline takes them
`default_nettype none
`include "fpu_settings.svh"

module fpu_issue_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  fpu_pkg::fpu_op_e      req_op,
    input  logic [63:0]           req_a,
    input  logic [63:0]           req_b,
    input  logic [`FPU_TAG_W-1:0] req_tag,
    input  logic                  advance,
    output logic                  issue_valid,
    output fpu_pkg::fpu_op_e      issue_op,
    output logic [63:0]           issue_a,
    output logic [63:0]           issue_b,
    output logic [`FPU_TAG_W-1:0] issue_tag
);
    localparam int ptr_w = $clog2(`FPU_QUEUE_DEPTH);

    fpu_pkg::fpu_op_e      op_q  [`FPU_QUEUE_DEPTH];
    logic [63:0]           a_q   [`FPU_QUEUE_DEPTH];
    logic [63:0]           b_q   [`FPU_QUEUE_DEPTH];
    logic [`FPU_TAG_W-1:0] tag_q [`FPU_QUEUE_DEPTH];

    logic [ptr_w-1:0] front;
    logic [ptr_w-1:0] tail;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop;

    always_comb begin
        req_ready   = count != (ptr_w + 1)'(`FPU_QUEUE_DEPTH);
        issue_valid = count != '0;
        push        = req_valid & req_ready;
        pop         = issue_valid & advance;
        tail        = front + ptr_w'(count); // wraps, depth is a power of two
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[tail]  <= req_op;
            a_q[tail]   <= req_a;
            b_q[tail]   <= req_b;
            tag_q[tail] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            front <= '0;
            count <= '0;
        end else begin
            if (pop) begin
                front <= front + ptr_w'(1);
            end
            count <= count + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop); // push and pop may overlap
        end
    end

    assign issue_op  = op_q[front];
    assign issue_a   = a_q[front];
    assign issue_b   = b_q[front];
    assign issue_tag = tag_q[front];

endmodule

`default_nettype wire

//--- rtl/fpu_normalize_round.sv
// uniforming and conversion stages: renormalize, pack and round, hold the response
`default_nettype none
`include "fpu_settings.svh"

module fpu_normalize_round (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ex_valid,
    input  logic [`FPU_TAG_W-1:0]  ex_tag,
    input  fpu_pkg::fpu_kind_e     ex_kind,
    input  logic                   ex_s,
    input  logic [`FPU_EXP_W-1:0]  ex_e,
    input  logic [`FPU_MANT_W-1:0] ex_m,
    input  logic                   resp_ready,
    output logic                   advance,
    output logic                   resp_valid,
    output logic [63:0]            resp_value,
    output logic [`FPU_TAG_W-1:0]  resp_tag
);
    localparam logic [5:0] hidden = 6'(`FPU_HIDDEN_POS);

    logic [5:0]             lead;
    logic                   un_s;
    logic [`FPU_EXP_W-1:0]  un_e;
    logic [`FPU_MANT_W-1:0] un_m;

    logic                   nr_valid;
    logic [`FPU_TAG_W-1:0]  nr_tag;
    fpu_pkg::fpu_kind_e     nr_kind;
    logic                   nr_s;
    logic [`FPU_EXP_W-1:0]  nr_e;
    logic [`FPU_MANT_W-1:0] nr_m;

    logic                   rnd_up;
    logic [62:0]            mag;
    logic [63:0]            pk_value;

    always_comb begin
        lead = '0;
        for (int i = 0; i < `FPU_MANT_W; i++) begin
            if (ex_m[i]) begin
                lead = 6'(i); // highest one wins
            end
        end
    end

    always_comb begin
        un_s = ex_s;
        un_e = ex_e;
        un_m = ex_m;
        if (ex_kind == fpu_pkg::kind_float) begin
            if (ex_m == '0) begin // exact cancellation gives +0
                un_s = 1'b0;
                un_e = '0;
            end else if (lead > hidden) begin
                un_m    = ex_m >> (lead - hidden);
                un_m[0] = |(ex_m & ((`FPU_MANT_W'(2) << (lead - hidden)) - `FPU_MANT_W'(1)));
                un_e    = ex_e + `FPU_EXP_W'(lead - hidden);
            end else begin
                un_m = ex_m << (hidden - lead); // exact, nothing shifted out
                un_e = ex_e - `FPU_EXP_W'(hidden - lead);
            end
        end
    end

    // stage 4: uniforming
    always_ff @(posedge clk) begin
        if (rst) begin
            nr_valid <= 1'b0;
        end else if (advance) begin
            nr_valid <= ex_valid;
        end
        if (advance) begin
            nr_tag  <= ex_tag;
            nr_kind <= ex_kind;
            nr_s    <= un_s;
            nr_e    <= un_e;
            nr_m    <= un_m;
        end
    end

    // round to nearest even, carry may ripple into the exponent
    always_comb begin
        rnd_up   = nr_m[1] & (nr_m[0] | nr_m[2]);
        mag      = {nr_e, nr_m[`FPU_HIDDEN_POS-1 -: `FPU_FRAC_W]} + 63'(rnd_up);
        pk_value = (nr_kind == fpu_pkg::kind_int) ? nr_m : {nr_s, mag};
    end

    assign advance = ~(resp_valid & ~resp_ready); // freeze under back-pressure

    // stage 5: conversion into the output register
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (advance) begin
            resp_valid <= nr_valid;
        end
        if (advance) begin
            resp_value <= pk_value;
            resp_tag   <= nr_tag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fpu_pkg.sv
// operation codes and result kinds shared by the FPU pipeline and its testbench
`default_nettype none

package fpu_pkg;

    typedef enum logic [3:0] {
        op_fadd   = 4'd0,
        op_fsub   = 4'd1,
        op_fsgnj  = 4'd2,
        op_fsgnjn = 4'd3,
        op_fsgnjx = 4'd4,
        op_fmin   = 4'd5,
        op_fmax   = 4'd6,
        op_feq    = 4'd7,
        op_flt    = 4'd8,
        op_fle    = 4'd9
    } fpu_op_e;

    // what the back end does with an execute result
    typedef enum logic [1:0] {
        kind_float = 2'd0, // renormalize, then round
        kind_int   = 2'd1, // raw 64-bit integer
        kind_pass  = 2'd2  // operand forwarded unchanged
    } fpu_kind_e;

endpackage

`default_nettype wire

//--- rtl/fpu_settings.svh
// shared constants of the double-precision FPU, included by the RTL and the testbench
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

`define FPU_QUEUE_DEPTH 4       // issue queue entries, power of two
`define FPU_TAG_W       8       // request tag returned with the result

// IEEE double layout
`define FPU_FRAC_W      52      // fraction field width
`define FPU_EXP_W       11      // exponent field width
`define FPU_SIGN_POS    63      // sign bit
`define FPU_EXP_BIAS    1023

// internal mantissa: hidden one, fraction, guard bit, sticky bit
`define FPU_MANT_W      64
`define FPU_HIDDEN_POS  54

`endif

//--- rtl/fpu_top.sv
// double-precision FPU top: issue queue followed by the five-stage pipeline
`default_nettype none
`include "fpu_settings.svh"

module fpu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  fpu_pkg::fpu_op_e      req_op,
    input  logic [63:0]           req_a,
    input  logic [63:0]           req_b,
    input  logic [`FPU_TAG_W-1:0] req_tag,
    output logic                  resp_valid,
    output logic [63:0]           resp_value,
    output logic [`FPU_TAG_W-1:0] resp_tag,
    input  logic                  resp_ready
);
    logic                   advance;

    logic                   issue_valid;
    fpu_pkg::fpu_op_e       issue_op;
    logic [63:0]            issue_a;
    logic [63:0]            issue_b;
    logic [`FPU_TAG_W-1:0]  issue_tag;

    logic                   al_valid;
    fpu_pkg::fpu_op_e       al_op;
    logic [`FPU_TAG_W-1:0]  al_tag;
    logic                   al_as;
    logic                   al_bs;
    logic [`FPU_EXP_W-1:0]  al_ae;
    logic [`FPU_EXP_W-1:0]  al_be;
    logic [`FPU_MANT_W-1:0] al_am;
    logic [`FPU_MANT_W-1:0] al_bm;
    logic [`FPU_MANT_W-1:0] al_a2;
    logic [`FPU_MANT_W-1:0] al_b2;
    logic [`FPU_EXP_W-1:0]  al_me;

    logic                   ex_valid;
    logic [`FPU_TAG_W-1:0]  ex_tag;
    fpu_pkg::fpu_kind_e     ex_kind;
    logic                   ex_s;
    logic [`FPU_EXP_W-1:0]  ex_e;
    logic [`FPU_MANT_W-1:0] ex_m;

    fpu_issue_queue u_queue (.*);

    fpu_unpack_align u_unpack_align (.*);

    fpu_execute u_execute (.*);

    fpu_normalize_round u_normalize_round (.*);

endmodule

`default_nettype wire

//--- rtl/fpu_unpack_align.sv
// split and alignment stages: operands to sign, exponent, mantissa and aligned signed values
`default_nettype none
`include "fpu_settings.svh"

module fpu_unpack_align (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  logic                   issue_valid,
    input  fpu_pkg::fpu_op_e       issue_op,
    input  logic [63:0]            issue_a,
    input  logic [63:0]            issue_b,
    input  logic [`FPU_TAG_W-1:0]  issue_tag,
    output logic                   al_valid,
    output fpu_pkg::fpu_op_e       al_op,
    output logic [`FPU_TAG_W-1:0]  al_tag,
    output logic                   al_as,
    output logic                   al_bs,
    output logic [`FPU_EXP_W-1:0]  al_ae,
    output logic [`FPU_EXP_W-1:0]  al_be,
    output logic [`FPU_MANT_W-1:0] al_am,
    output logic [`FPU_MANT_W-1:0] al_bm,
    output logic [`FPU_MANT_W-1:0] al_a2,
    output logic [`FPU_MANT_W-1:0] al_b2,
    output logic [`FPU_EXP_W-1:0]  al_me
);
    // hidden one at FPU_HIDDEN_POS, a zero exponent leaves it clear
    function automatic logic [`FPU_MANT_W-1:0] split_mant(input logic [63:0] x);
        logic [`FPU_MANT_W-1:0] m;
        m = '0;
        m[`FPU_HIDDEN_POS] = x[`FPU_FRAC_W +: `FPU_EXP_W] != '0;
        m[`FPU_HIDDEN_POS-1 -: `FPU_FRAC_W] = x[`FPU_FRAC_W-1:0];
        return m;
    endfunction

    // one extra low bit keeps guard, round and sticky apart for subtraction
    function automatic logic [`FPU_MANT_W-1:0] align(input logic [`FPU_MANT_W-1:0] m,
                                                     input logic [`FPU_EXP_W-1:0]  sh,
                                                     input logic                   s);
        logic [`FPU_MANT_W-1:0] ext;
        logic [`FPU_MANT_W-1:0] v;
        ext  = m << 1;
        v    = ext >> sh;
        v[0] = v[0] | (|(ext & ((`FPU_MANT_W'(1) << sh) - `FPU_MANT_W'(1)))); // sticky
        return s ? -v : v;
    endfunction

    logic                   sp_valid;
    fpu_pkg::fpu_op_e       sp_op;
    logic [`FPU_TAG_W-1:0]  sp_tag;
    logic                   sp_as;
    logic                   sp_bs;
    logic [`FPU_EXP_W-1:0]  sp_ae;
    logic [`FPU_EXP_W-1:0]  sp_be;
    logic [`FPU_MANT_W-1:0] sp_am;
    logic [`FPU_MANT_W-1:0] sp_bm;
    logic [`FPU_EXP_W-1:0]  me;

    // stage 1: split
    always_ff @(posedge clk) begin
        if (rst) begin
            sp_valid <= 1'b0;
        end else if (advance) begin
            sp_valid <= issue_valid;
        end
        if (advance) begin
            sp_op  <= issue_op;
            sp_tag <= issue_tag;
            sp_as  <= issue_a[`FPU_SIGN_POS];
            sp_bs  <= issue_b[`FPU_SIGN_POS];
            sp_ae  <= issue_a[`FPU_FRAC_W +: `FPU_EXP_W];
            sp_be  <= issue_b[`FPU_FRAC_W +: `FPU_EXP_W];
            sp_am  <= split_mant(issue_a);
            sp_bm  <= split_mant(issue_b);
        end
    end

    assign me = (sp_ae > sp_be) ? sp_ae : sp_be; // common exponent

    // stage 2: alignment
    always_ff @(posedge clk) begin
        if (rst) begin
            al_valid <= 1'b0;
        end else if (advance) begin
            al_valid <= sp_valid;
        end
        if (advance) begin
            al_op  <= sp_op;
            al_tag <= sp_tag;
            al_as  <= sp_as;
            al_bs  <= sp_bs;
            al_ae  <= sp_ae;
            al_be  <= sp_be;
            al_am  <= sp_am;
            al_bm  <= sp_bm;
            al_a2  <= align(sp_am, me - sp_ae, sp_as);
            al_b2  <= align(sp_bm, me - sp_be, sp_bs);
            al_me  <= me;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/fpu_pkg.sv
rtl/fpu_issue_queue.sv
rtl/fpu_unpack_align.sv
rtl/fpu_execute.sv
rtl/fpu_normalize_round.sv
rtl/fpu_top.sv
testbench/fpu_asserts.sv
testbench/fpu_tb.sv

//--- testbench/fpu_asserts.sv
// handshake and reset checks on the FPU top level, attached by bind from the testbench
`default_nettype none
`include "fpu_settings.svh"

module fpu_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  req_ready,
    input logic                  resp_valid,
    input logic                  resp_ready,
    input logic [63:0]           resp_value,
    input logic [`FPU_TAG_W-1:0] resp_tag
);
    // a stalled response keeps its valid, value and tag
    property resp_held;
        @(posedge clk) disable iff (rst)
            resp_valid && !resp_ready |=> resp_valid && $stable(resp_value) && $stable(resp_tag);
    endproperty

    property ready_after_reset;
        @(posedge clk) $fell(rst) |-> req_ready; // queue empty
    endproperty

    property quiet_in_reset;
        @(posedge clk) rst |=> !resp_valid;
    endproperty

    resp_held_a: assert property (resp_held)
        else $error("response changed while held by back-pressure");

    ready_after_reset_a: assert property (ready_after_reset)
        else $error("req_ready low in the first cycle after reset");

    quiet_in_reset_a: assert property (quiet_in_reset)
        else $error("resp_valid high during reset");

endmodule

`default_nettype wire

//--- testbench/fpu_tb.sv
// simulation top that drives the FPU through a request table and a back-pressure burst
`default_nettype none
`include "fpu_settings.svh"

module fpu_tb;
    localparam int          n_random   = 64;
    localparam int          wait_limit = 2000;          // cycles allowed per wait
    localparam logic [31:0] seed       = 32'hc8e851e6;

    localparam logic [63:0] d_one     = 64'h3ff0_0000_0000_0000;
    localparam logic [63:0] d_one_ulp = 64'h3ff0_0000_0000_0001; // 1.0 plus one ulp
    localparam logic [63:0] d_1p5     = 64'h3ff8_0000_0000_0000;
    localparam logic [63:0] d_1p25    = 64'h3ff4_0000_0000_0000;
    localparam logic [63:0] d_m1p25   = 64'hbff4_0000_0000_0000;
    localparam logic [63:0] d_three   = 64'h4008_0000_0000_0000;
    localparam logic [63:0] d_m2      = 64'hc000_0000_0000_0000;
    localparam logic [63:0] d_m0p75   = 64'hbfe8_0000_0000_0000;
    localparam logic [63:0] d_tenth   = 64'h3fb9_9999_9999_999a;
    localparam logic [63:0] d_hundred = 64'h4059_0000_0000_0000;
    localparam logic [63:0] d_half_ul = 64'h3ca0_0000_0000_0000; // 2^-53
    localparam logic [63:0] d_tiny    = 64'h3c30_0000_0000_0000; // 2^-60

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  req_valid;
    logic                  req_ready;
    fpu_pkg::fpu_op_e      req_op;
    logic [63:0]           req_a;
    logic [63:0]           req_b;
    logic [`FPU_TAG_W-1:0] req_tag;
    logic                  resp_valid;
    logic [63:0]           resp_value;
    logic [`FPU_TAG_W-1:0] resp_tag;
    logic                  resp_ready;

    string            row_name [$]; // tag of a row is its index
    fpu_pkg::fpu_op_e row_op   [$];
    logic [63:0]      row_a    [$];
    logic [63:0]      row_b    [$];
    logic [63:0]      row_exp  [$];

    logic [31:0] lfsr;
    logic        throttle;   // random resp_ready while set
    int          n_directed;
    int          sent;
    int          received;
    int          n_checks;
    int          n_errors;
    int          n_timeouts;

    fpu_top UUT (.*);

    bind fpu_top fpu_asserts u_asserts (
        .clk(clk), .rst(rst), .req_ready(req_ready), .resp_valid(resp_valid),
        .resp_ready(resp_ready), .resp_value(resp_value), .resp_tag(resp_tag)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0); // galois step
        return b;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    // reference behaviour of each operation
    function automatic logic [63:0] model_result(input fpu_pkg::fpu_op_e op,
                                                 input logic [63:0] a, input logic [63:0] b);
        real ra;
        real rb;
        ra = $bitstoreal(a);
        rb = $bitstoreal(b);
        case (op)
            fpu_pkg::op_fadd:   return $realtobits(ra + rb);
            fpu_pkg::op_fsub:   return $realtobits(ra - rb);
            fpu_pkg::op_fsgnj:  return {b[63], a[62:0]};
            fpu_pkg::op_fsgnjn: return {~b[63], a[62:0]};
            fpu_pkg::op_fsgnjx: return {a[63] ^ b[63], a[62:0]};
            fpu_pkg::op_fmin:   return (ra < rb) ? a : b;
            fpu_pkg::op_fmax:   return (ra > rb) ? a : b;
            fpu_pkg::op_feq:    return 64'(ra == rb);
            fpu_pkg::op_flt:    return 64'(ra < rb);
            default:            return 64'(ra <= rb);
        endcase
    endfunction

    task automatic add_row(input string name, input fpu_pkg::fpu_op_e op,
                           input logic [63:0] a, input logic [63:0] b);
        row_name.push_back(name);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
        row_exp.push_back(model_result(op, a, b));
    endtask

    task automatic build_table();
        logic             sa;
        logic             sb;
        logic [10:0]      ea;
        logic [10:0]      eb;
        logic [51:0]      fa;
        logic [51:0]      fb;
        fpu_pkg::fpu_op_e op;
        add_row("fadd equal exponents", fpu_pkg::op_fadd, d_1p5, d_1p25);
        add_row("fadd distant exponents", fpu_pkg::op_fadd, d_one, d_tiny);
        add_row("fadd mixed signs", fpu_pkg::op_fadd, d_hundred, d_m0p75);
        add_row("fadd inexact", fpu_pkg::op_fadd, d_tenth, d_three);
        add_row("fadd zero operand", fpu_pkg::op_fadd, d_m0p75, 64'h0);
        add_row("fadd cancellation", fpu_pkg::op_fadd, d_1p25, d_m1p25);
        add_row("fadd tie to even", fpu_pkg::op_fadd, d_one, d_half_ul);
        add_row("fadd tie rounds up", fpu_pkg::op_fadd, d_one_ulp, d_half_ul);
        add_row("fsub equal exponents", fpu_pkg::op_fsub, d_1p5, d_1p25);
        add_row("fsub distant exponents", fpu_pkg::op_fsub, d_hundred, d_tiny);
        add_row("fsub cancellation", fpu_pkg::op_fsub, d_tenth, d_tenth);
        add_row("fsub negative result", fpu_pkg::op_fsub, d_one, d_three);
        add_row("fsgnj", fpu_pkg::op_fsgnj, d_m0p75, d_three);
        add_row("fsgnjn", fpu_pkg::op_fsgnjn, d_1p5, d_three);
        add_row("fsgnjx", fpu_pkg::op_fsgnjx, d_m0p75, d_m2);
        add_row("fsgnjx mixed signs", fpu_pkg::op_fsgnjx, d_1p5, d_m2);
        add_row("fmin negative", fpu_pkg::op_fmin, d_m2, d_1p5);
        add_row("fmin positive", fpu_pkg::op_fmin, d_three, d_1p25);
        add_row("fmin zero", fpu_pkg::op_fmin, 64'h0, d_m0p75);
        add_row("fmax negative", fpu_pkg::op_fmax, d_m2, d_1p5);
        add_row("fmax zero", fpu_pkg::op_fmax, 64'h0, d_m0p75);
        add_row("feq equal", fpu_pkg::op_feq, d_1p5, d_1p5);
        add_row("feq unequal", fpu_pkg::op_feq, d_1p5, d_1p25);
        add_row("flt less", fpu_pkg::op_flt, d_m2, d_one);
        add_row("flt equal", fpu_pkg::op_flt, d_one, d_one);
        add_row("flt distant", fpu_pkg::op_flt, d_three, d_hundred);
        add_row("fle equal", fpu_pkg::op_fle, d_one, d_one);
        add_row("fle greater", fpu_pkg::op_fle, d_three, d_m0p75);
        add_row("fle less", fpu_pkg::op_fle, d_m0p75, d_tenth);
        n_directed = row_name.size();
        // exponents stay near each other so sums remain normal
        for (int i = 0; i < n_random; i++) begin
            op = lfsr_bit() ? fpu_pkg::op_fsub : fpu_pkg::op_fadd;
            sa = lfsr_bit();
            ea = 11'd1000 + 11'(rand_bits(6));
            fa = 52'(rand_bits(52));
            sb = lfsr_bit();
            eb = ea - 11'd3 + 11'(rand_bits(3));
            fb = 52'(rand_bits(52));
            add_row($sformatf("random %0d", i), op, {sa, ea, fa}, {sb, eb, fb});
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        n_timeouts++;
        $display("timeout after %0d cycles while %s", wait_limit, what);
    endtask

    task automatic send_row(input int idx, output logic ok);
        int waited;
        ok = 1'b1;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = row_op[idx];
        req_a     = row_a[idx];
        req_b     = row_b[idx];
        req_tag   = `FPU_TAG_W'(idx);
        while (!req_ready) begin
            if (sent - received < `FPU_QUEUE_DEPTH) begin // queue cannot be full yet
                n_errors++;
                $display("req_ready low with only %0d requests outstanding", sent - received);
            end
            if (waited == wait_limit) begin
                report_timeout("waiting for req_ready");
                ok = 1'b0;
                return;
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        sent++;
    endtask

    task automatic wait_drain(output logic ok);
        int waited;
        ok = 1'b1;
        waited = 0;
        while (received < sent) begin
            if (waited == wait_limit) begin
                report_timeout("waiting for outstanding responses");
                ok = 1'b0;
                return;
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic record_response(input logic [`FPU_TAG_W-1:0] tag, input logic [63:0] value);
        check_value("response order", 64'(received % 256), 64'(tag));
        if (int'(tag) < row_name.size()) begin
            check_value(row_name[tag], row_exp[tag], value);
        end else begin
            n_errors++;
            $display("response with unknown tag %0d", tag);
        end
        received++;
    endtask

    task automatic run_tests();
        logic ok;
        for (int i = 0; i < n_directed; i++) begin
            send_row(i, ok);
            if (!ok) return;
        end
        @(negedge clk);
        req_valid = 1'b0;
        wait_drain(ok);
        if (!ok) return;
        @(posedge clk);
        throttle = 1'b1; // back-pressure burst
        for (int i = n_directed; i < row_name.size(); i++) begin
            send_row(i, ok);
            if (!ok) return;
        end
        @(negedge clk);
        req_valid = 1'b0;
        wait_drain(ok);
        if (!ok) return;
        @(posedge clk);
        throttle = 1'b0;
        repeat (10) @(negedge clk); // stray responses would show up in this quiet period
    endtask

    // resp_ready changes on the falling edge and a transfer counts at the rising edge
    initial begin : collect
        logic [63:0]           value;
        logic [`FPU_TAG_W-1:0] tag;
        logic                  took;
        resp_ready = 1'b0;
        forever begin
            @(negedge clk);
            resp_ready = throttle ? (lfsr_bit() & lfsr_bit()) : 1'b1;
            took  = !rst && resp_valid && resp_ready;
            value = resp_value;
            tag   = resp_tag;
            @(posedge clk);
            if (took) begin
                record_response(tag, value);
            end
        end
    end

    initial begin
        lfsr       = seed;
        throttle   = 1'b0;
        sent       = 0;
        received   = 0;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_op     = fpu_pkg::op_fadd;
        req_a      = '0;
        req_b      = '0;
        req_tag    = '0;
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        run_tests();
        $display("checks %0d, errors %0d, timeouts %0d, responses %0d of %0d",
                 n_checks, n_errors, n_timeouts, received, row_name.size());
        if (n_errors == 0 && n_timeouts == 0 && received == row_name.size()) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
